/* common/phase_config.svh */
`ifndef PHASE_CONFIG_SVH
`define PHASE_CONFIG_SVH

// sample width of both input waves
`define PHASE_SAMPLE_W 8

// cycle counter width, bounds the longest period
`define PHASE_CNT_W 16

// how far a sample may sit from a level and still count as near
`define PHASE_THRESHOLD 4

// degrees in one full turn
`define PHASE_DEG_TURN 360

// phase result width, holds 0..359
`define PHASE_OUT_W 9

`endif

/* common/phase_pkg.sv */
`default_nettype none

package phase_pkg;

`include "phase_config.svh"

    // one unsigned input sample
    typedef logic [`PHASE_SAMPLE_W-1:0] sample_t;

    // cycle count between events
    typedef logic [`PHASE_CNT_W-1:0] count_t;

    // phase in whole degrees
    typedef logic [`PHASE_OUT_W-1:0] degree_t;

    // tracker events
    // both fields are single-cycle pulses
    typedef struct packed {
        logic trough_hit;
        logic peak_hit;
    } wave_event_t;

    // captured lag and period
    // stays put while the divider works on it
    typedef struct packed {
        count_t lag;
        count_t period;
    } meas_t;

    // controller sequence
    typedef enum logic [1:0] {
        ARM,
        MEASURE,
        DIVIDE
    } ctrl_state_t;

endpackage

`default_nettype wire

/* verilog/wave_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "phase_config.svh"

module wave_tracker (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire phase_pkg::sample_t sample,
    input  wire phase_pkg::sample_t amplitude,
    output phase_pkg::wave_event_t  ev
);
    import phase_pkg::*;

    typedef enum logic [1:0] {
        WAIT_TROUGH,
        WAIT_PEAK,
        AT_PEAK
    } trk_state_t;

    trk_state_t  state;
    trk_state_t  state_next;
    wave_event_t ev_next;
    sample_t     trough;
    sample_t     d_trough;
    sample_t     d_peak;
    logic        near_trough;
    logic        near_peak;

    // 256 - amplitude, wraps naturally in sample width
    assign trough = sample_t'(0) - amplitude;

    // absolute differences, ordered so nothing underflows
    assign d_trough = (sample >= trough) ? sample - trough : trough - sample;
    assign d_peak   = (sample >= amplitude) ? sample - amplitude : amplitude - sample;

    assign near_trough = (d_trough <= sample_t'(`PHASE_THRESHOLD));
    assign near_peak   = (d_peak <= sample_t'(`PHASE_THRESHOLD));

    always_comb begin
        state_next = state;
        ev_next    = '0;
        case (state)
            // nothing counts until the trough has been visited once
            WAIT_TROUGH: begin
                if (near_trough) begin
                    state_next         = WAIT_PEAK;
                    ev_next.trough_hit = 1'b1;
                end
            end
            WAIT_PEAK: begin
                if (near_peak) begin
                    state_next       = AT_PEAK;
                    ev_next.peak_hit = 1'b1;
                end
            end
            // lingering at the peak gives no second event
            AT_PEAK: begin
                if (near_trough) begin
                    state_next         = WAIT_PEAK;
                    ev_next.trough_hit = 1'b1;
                end
            end
            default: begin
                state_next = WAIT_TROUGH;
            end
        endcase
    end

    // events leave one cycle after the qualifying sample
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= WAIT_TROUGH;
            ev    <= '0;
        end else begin
            state <= state_next;
            ev    <= ev_next;
        end
    end

endmodule

`default_nettype wire

/* verilog/measure_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module measure_ctrl (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire phase_pkg::wave_event_t ev_a,
    input  wire phase_pkg::wave_event_t ev_b,
    input  wire                    ovf,
    input  wire                    div_done,
    output logic                   cnt_clear,
    output logic                   cnt_run,
    output logic                   lag_capture,
    output logic                   period_capture,
    output logic                   div_start
);
    import phase_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;
    // a B peak has been captured in the current period
    logic        lag_seen;

    // counter only advances while a period is open
    assign cnt_run = (state == MEASURE);

    // outputs react in the same cycle as the events
    // so the counter sees clear and capture without extra delay
    always_comb begin
        state_next     = state;
        cnt_clear      = 1'b0;
        lag_capture    = 1'b0;
        period_capture = 1'b0;
        div_start      = 1'b0;
        case (state)
            // wait for an A peak to open the first period
            ARM: begin
                if (ev_a.peak_hit) begin
                    cnt_clear  = 1'b1;
                    state_next = MEASURE;
                end
            end
            MEASURE: begin
                if (ovf) begin
                    // period too long, give up on it
                    state_next = ARM;
                end else begin
                    // only the first B peak of a period
                    lag_capture = ev_b.peak_hit && !lag_seen;
                    if (ev_a.peak_hit) begin
                        period_capture = 1'b1;
                        if (lag_seen || ev_b.peak_hit) begin
                            div_start  = 1'b1;
                            state_next = DIVIDE;
                        end else begin
                            // no B peak this period, restart at this A peak
                            cnt_clear = 1'b1;
                        end
                    end
                end
            end
            // events are ignored until the result is out
            DIVIDE: begin
                if (div_done) begin
                    state_next = ARM;
                end
            end
            default: begin
                state_next = ARM;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ARM;
        end else begin
            state <= state_next;
        end
    end

    // cleared on every new period and outside MEASURE
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lag_seen <= 1'b0;
        end else if (cnt_clear || state != MEASURE) begin
            lag_seen <= 1'b0;
        end else if (lag_capture) begin
            lag_seen <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* verilog/cycle_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module cycle_counter (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              cnt_clear,
    input  wire              cnt_run,
    input  wire              lag_capture,
    input  wire              period_capture,
    output phase_pkg::meas_t meas,
    output logic             ovf
);
    import phase_pkg::*;

    // cycles since the current period began
    count_t count;

    // count saturates, so ovf holds until the next clear
    assign ovf = (count == '1);

    // clear loads 1 so the count lines up with the event delay
    // clear wins over run
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (cnt_clear) begin
            count <= count_t'(1);
        end else if (cnt_run && !ovf) begin
            count <= count + count_t'(1);
        end
    end

    // capture registers
    // untouched while no capture pulse arrives, so the divider can read them
    // across its whole run while the count moves on
    always_ff @(posedge clk) begin
        if (lag_capture) begin
            meas.lag <= count;
        end
        if (period_capture) begin
            meas.period <= count;
        end
    end

endmodule

`default_nettype wire

/* phase_divider/phase_divider.sv */
`timescale 1ns/1ps
`default_nettype none

`include "phase_config.svh"

module phase_divider (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   div_start,
    input  wire phase_pkg::meas_t meas,
    output phase_pkg::degree_t    phase,
    output logic                  div_done
);
    import phase_pkg::*;

    // room for lag * 360 and for the period shifted by the top quotient bit
    localparam int REM_W = `PHASE_CNT_W + `PHASE_OUT_W;
    localparam logic [REM_W-1:0] DEG_TURN = REM_W'(`PHASE_DEG_TURN);
    localparam logic [3:0] TOP_BIT = 4'(`PHASE_OUT_W - 1);

    logic [REM_W-1:0] rem;
    logic [REM_W-1:0] dividend;
    logic [REM_W-1:0] cur_rem;
    logic [REM_W-1:0] trial;
    logic [3:0]       bit_idx;
    logic             busy;
    logic             first;
    logic             fits;
    degree_t          quo;
    degree_t          quo_next;

    // lag * 360, the dividend
    assign dividend = REM_W'(meas.lag) * DEG_TURN;

    // the period only settles at the edge that raises div_start,
    // so the operands are picked up by the first step and not at start
    assign cur_rem = first ? dividend : rem;
    assign trial   = REM_W'(meas.period) << bit_idx;
    assign fits    = (cur_rem >= trial);

    always_comb begin
        quo_next          = quo;
        quo_next[bit_idx] = fits;
    end

    // one quotient bit per cycle, msb first
    // done rises exactly 10 cycles after start
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            first    <= 1'b0;
            bit_idx  <= '0;
            phase    <= '0;
            div_done <= 1'b0;
        end else begin
            div_done <= 1'b0;
            if (div_start) begin
                busy    <= 1'b1;
                first   <= 1'b1;
                bit_idx <= TOP_BIT;
            end else if (busy) begin
                first   <= 1'b0;
                bit_idx <= bit_idx - 4'd1;
                if (bit_idx == 4'd0) begin
                    busy     <= 1'b0;
                    div_done <= 1'b1;
                    // lag equal to the period is a full turn, reads as 0
                    if (quo_next == degree_t'(`PHASE_DEG_TURN)) begin
                        phase <= '0;
                    end else begin
                        phase <= quo_next;
                    end
                end
            end
        end
    end

    // restoring step, remainder and partial quotient
    always_ff @(posedge clk) begin
        if (div_start) begin
            quo <= '0;
        end else if (busy) begin
            quo <= quo_next;
            rem <= fits ? cur_rem - trial : cur_rem;
        end
    end

endmodule

`default_nettype wire

/* verilog/phase_meter_top.sv */
`timescale 1ns/1ps
`default_nettype none

module phase_meter_top (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire phase_pkg::sample_t wave_a,
    input  wire phase_pkg::sample_t wave_b,
    input  wire phase_pkg::sample_t amplitude,
    output phase_pkg::degree_t      phase,
    output logic                    phase_valid
);
    import phase_pkg::*;

    wave_event_t ev_a;
    wave_event_t ev_b;
    meas_t       meas;
    logic        cnt_clear;
    logic        cnt_run;
    logic        lag_capture;
    logic        period_capture;
    logic        div_start;
    logic        ovf;

    // reference channel, its peaks frame the period
    wave_tracker trk_a (
        .clk       (clk),
        .rst_n     (rst_n),
        .sample    (wave_a),
        .amplitude (amplitude),
        .ev        (ev_a)
    );

    // measured channel, its first peak marks the lag
    wave_tracker trk_b (
        .clk       (clk),
        .rst_n     (rst_n),
        .sample    (wave_b),
        .amplitude (amplitude),
        .ev        (ev_b)
    );

    // phase_valid is the divider's done pulse, also fed back to the FSM
    measure_ctrl u_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .ev_a           (ev_a),
        .ev_b           (ev_b),
        .ovf            (ovf),
        .div_done       (phase_valid),
        .cnt_clear      (cnt_clear),
        .cnt_run        (cnt_run),
        .lag_capture    (lag_capture),
        .period_capture (period_capture),
        .div_start      (div_start)
    );

    cycle_counter u_counter (
        .clk            (clk),
        .rst_n          (rst_n),
        .cnt_clear      (cnt_clear),
        .cnt_run        (cnt_run),
        .lag_capture    (lag_capture),
        .period_capture (period_capture),
        .meas           (meas),
        .ovf            (ovf)
    );

    phase_divider u_divider (
        .clk       (clk),
        .rst_n     (rst_n),
        .div_start (div_start),
        .meas      (meas),
        .phase     (phase),
        .div_done  (phase_valid)
    );

endmodule

`default_nettype wire

/* verification/phase_meter_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

`include "phase_config.svh"

module phase_meter_asserts (
    input wire                     clk,
    input wire                     rst_n,
    input wire phase_pkg::degree_t phase,
    input wire                     phase_valid,
    input wire                     div_start
);
    import phase_pkg::*;

    // one cycle to load, one per quotient bit
    localparam int DIV_LATENCY = `PHASE_OUT_W + 1;

    // failed checks so far
    int fail_count = 0;

    // result strobe never lasts two cycles
    valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        phase_valid |=> !phase_valid)
    else begin
        fail_count++;
        $error("phase_valid held longer than one cycle");
    end

    // full turn folds to 0, so 359 is the top
    phase_range: assert property (@(posedge clk) disable iff (!rst_n)
        phase_valid |-> phase < degree_t'(`PHASE_DEG_TURN))
    else begin
        fail_count++;
        $error("phase %0d out of range", phase);
    end

    div_latency: assert property (@(posedge clk) disable iff (!rst_n)
        div_start |-> ##DIV_LATENCY phase_valid)
    else begin
        fail_count++;
        $error("divider done missing after start");
    end

    // and never without a start at the right distance
    done_source: assert property (@(posedge clk) disable iff (!rst_n)
        phase_valid |-> $past(div_start, DIV_LATENCY))
    else begin
        fail_count++;
        $error("divider done without matching start");
    end

    // quiet during reset and one cycle past it
    reset_quiet: assert property (@(posedge clk)
        !rst_n |=> !phase_valid && !div_start && phase == '0)
    else begin
        fail_count++;
        $error("outputs active around reset");
    end

endmodule

bind phase_meter_top phase_meter_asserts u_asserts (
    .clk         (clk),
    .rst_n       (rst_n),
    .phase       (phase),
    .phase_valid (phase_valid),
    .div_start   (div_start)
);

`default_nettype wire

/* verification/phase_meter_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "phase_config.svh"

module phase_meter_tb;
    import phase_pkg::*;

    localparam int CLK_HALF = 4;
    localparam int RST_CYCLES = 4;

    logic    clk;
    logic    rst_n;
    sample_t wave_a;
    sample_t wave_b;
    sample_t amplitude;
    degree_t phase;
    logic    phase_valid;

    // wave settings of the running case
    int      period;
    int      delay;
    int      n;
    logic    b_flat;
    sample_t hist [0:255];
    degree_t expected_phase;

    int      error_count;
    int      result_count;
    int      fail_tests;
    integer  seed;

    phase_meter_top dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .wave_a      (wave_a),
        .wave_b      (wave_b),
        .amplitude   (amplitude),
        .phase       (phase),
        .phase_valid (phase_valid)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // every result matches the delay and period in force
    check_phase: assert property (@(posedge clk) disable iff (!rst_n)
        phase_valid |-> phase == expected_phase)
    else begin
        error_count++;
        $display("Error: %0t ns: phase %0d, expected %0d",
                 $time, $sampled(phase), expected_phase);
    end

    // flat B channel has no peaks, so no result
    check_silent: assert property (@(posedge clk) disable iff (!rst_n)
        b_flat |-> !phase_valid)
    else begin
        error_count++;
        $display("Error: %0t ns: phase_valid while wave_b is flat", $time);
    end

    // sync reset clears the result register
    check_reset: assert property (@(posedge clk)
        !rst_n |=> phase == '0 && !phase_valid)
    else begin
        error_count++;
        $display("Error: %0t ns: phase %0d or phase_valid not cleared by reset",
                 $time, $sampled(phase));
    end

    // triangle from trough up to the peak and back, peak at k = p/2
    function automatic sample_t tri_sample(input int k, input int p, input int amp);
        int lo;
        int span;
        int rise;
        lo   = 256 - amp;
        span = amp - lo;
        rise = p / 2;
        if (k <= rise) begin
            return sample_t'(lo + span * k / rise);
        end else begin
            return sample_t'(lo + span * (p - k) / (p - rise));
        end
    endfunction

    // whole degrees, rounded down
    function automatic degree_t expected_deg(input int d, input int p);
        return degree_t'((d * `PHASE_DEG_TURN) / p);
    endfunction

    // one sample per falling edge, B reads A's history D samples back
    task automatic step();
        sample_t a_val;
        @(negedge clk);
        a_val = tri_sample(n % period, period, int'(amplitude));
        hist[8'(n)] = a_val;
        wave_a = a_val;
        if (b_flat || n < delay) begin
            wave_b = sample_t'(256 - int'(amplitude));
        end else begin
            wave_b = hist[8'(n - delay)];
        end
        n++;
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        n = 0;
        repeat (RST_CYCLES) step();
        rst_n = 1'b1;
    endtask

    task automatic start_case(input int p, input int d, input int amp);
        period         = p;
        delay          = d;
        amplitude      = sample_t'(amp);
        expected_phase = expected_deg(d, p);
        apply_reset();
    endtask

    // window restarts after each result
    task automatic collect(input int want, input string name, output int got);
        int cycles;
        int limit;
        got    = 0;
        cycles = 0;
        limit  = 4 * period + 100;
        while (got < want && cycles < limit) begin
            step();
            cycles++;
            if (phase_valid) begin
                got++;
                cycles = 0;
            end
        end
        result_count += got;
        if (got < want) begin
            error_count++;
            $display("%s: no phase result arrived within %0d cycles", name, limit);
        end
    endtask

    task automatic report(input string name, input int errs_before, input int got);
        if (error_count == errs_before) begin
            $display("%s: ok, %0d results", name, got);
        end else begin
            fail_tests++;
            $display("%s: failed, %0d errors", name, error_count - errs_before);
        end
    endtask

    initial begin
        int errs;
        int got;
        int total;
        int p;
        int d;
        int amp;
        int cycles;
        rst_n          = 1'b0;
        wave_a         = '0;
        wave_b         = '0;
        amplitude      = sample_t'(200);
        period         = 40;
        delay          = 0;
        n              = 0;
        b_flat         = 1'b0;
        expected_phase = '0;
        error_count    = 0;
        result_count   = 0;
        fail_tests     = 0;
        seed           = 32'hdb78e3d7;

        // equal waves, then one sample apart
        errs = error_count;
        start_case(40, 0, 200);
        collect(3, "test 1", got);
        total = got;
        start_case(40, 1, 200);
        collect(3, "test 1", got);
        report("test 1 equal waves and one sample delay", errs, total + got);

        // quarter and half period, several results each
        errs = error_count;
        start_case(64, 16, 200);
        collect(4, "test 2", got);
        total = got;
        start_case(64, 32, 200);
        collect(4, "test 2", got);
        report("test 2 quarter and half period", errs, total + got);

        errs  = error_count;
        total = 0;
        repeat (20) begin
            p   = 16 + int'($unsigned($random(seed)) % 185);
            d   = 1 + int'($unsigned($random(seed)) % (p - 1));
            amp = 150 + int'($unsigned($random(seed)) % 101);
            start_case(p, d, amp);
            collect(2, "test 3", got);
            total += got;
        end
        report("test 3 random period, delay and amplitude", errs, total);

        // ten quiet periods, then B resumes at its own trough
        errs   = error_count;
        b_flat = 1'b1;
        start_case(80, 20, 180);
        repeat (10 * period) step();
        cycles = 0;
        while (b_flat && cycles < 2 * period) begin
            step();
            cycles++;
            if ((n - delay) % period == 0) begin
                b_flat = 1'b0;
            end
        end
        collect(2, "test 4", got);
        report("test 4 flat wave_b then resume", errs, got);

        // reset lands after the lag capture, before the period ends
        errs = error_count;
        start_case(100, 30, 220);
        collect(1, "test 5", got);
        total = got;
        repeat (period + period / 4) step();
        apply_reset();
        collect(2, "test 5", got);
        report("test 5 reset mid-measurement", errs, total + got);

        $display("summary: 5 tests, %0d failed, %0d results, %0d errors, %0d bound failures",
                 fail_tests, result_count, error_count, dut.u_asserts.fail_count);
        if (error_count == 0 && fail_tests == 0 && dut.u_asserts.fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+common
common/phase_pkg.sv
verilog/wave_tracker.sv
verilog/measure_ctrl.sv
verilog/cycle_counter.sv
phase_divider/phase_divider.sv
verilog/phase_meter_top.sv
verification/phase_meter_asserts.sv
verification/phase_meter_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the phase meter testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=phase_meter_sim

verilator --binary --timing --assert -f files.f --top-module phase_meter_tb \
    --Mdir obj_dir -o "$BIN"
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
    exit 1
fi
if ! grep -q ">>> PASS" "$LOG"; then
    echo "simulation ended without a verdict"
    exit 1
fi
exit 0
